// File: common/fir_pkg.sv
package fir_pkg;

   // sample and coefficient width
   localparam int DSIZE = 16;

   // index field of a coefficient command, up to 16 taps per half
   localparam int COEF_IDX_W = 4;

   // input sample and coefficient
   typedef logic signed [DSIZE-1:0] sample_t;
   typedef logic signed [DSIZE-1:0] coef_t;

   // sum of a near and a far sample, one guard bit
   typedef logic signed [DSIZE:0] preadd_t;

   // product, cascade sum and filter output
   // wraps in 32 bits, no rounding or saturation
   typedef logic signed [2*DSIZE-1:0] acc_t;

   // host commands to the coefficient bank
   typedef enum logic [1:0]
   {
      COEF_WRITE  = 2'b01,   // value into shadow slot index
      COEF_COMMIT = 2'b10    // shadow set into active set
   } coef_op_t;

   // one command word, 22 bits
   typedef struct packed
   {
      coef_op_t                op;
      logic [COEF_IDX_W-1:0]   index;
      coef_t                   value;
   } coef_cmd_t;

endpackage

// File: fir/fir_delay_line.sv
`timescale 1ns/10ps

// far end of the symmetric window, 2*nbtap accepted samples behind the input
module fir_delay_line #(
   parameter int nbtap = 4
)
(
   input  logic             clk,
   input  logic             advance,
   input  fir_pkg::sample_t din,
   output fir_pkg::sample_t dout
);

   import fir_pkg::*;

   localparam int DEPTH = 2*nbtap;

   sample_t shift_q [DEPTH];   // maps well onto shift register primitives

   always_ff @(posedge clk)
   begin
      if (advance)
      begin
         shift_q[0] <= din;
         for (int i = 1; i < DEPTH; i++)
         begin
            shift_q[i] <= shift_q[i-1];
         end
      end
   end

   assign dout = shift_q[DEPTH-1];   // shared by every tap

endmodule

// File: fir/fir_sym_tap.sv
`timescale 1ns/10ps

// one element of the even symmetric systolic array
module fir_sym_tap
(
   input  logic             clk,
   input  logic             advance,
   input  fir_pkg::coef_t   coef,
   input  fir_pkg::sample_t din,
   input  fir_pkg::sample_t dfar,
   input  fir_pkg::acc_t    casc_in,
   output fir_pkg::sample_t dnext,
   output fir_pkg::acc_t    casc_out
);

   import fir_pkg::*;

   coef_t   coef_q;
   sample_t near_q;      // first stage of the data chain
   sample_t near2_q;     // second stage, also feeds the next tap
   sample_t far_q;
   preadd_t preadd_q;
   acc_t    product_q;

   always_ff @(posedge clk)
   begin
      if (advance)
      begin
         coef_q    <= coef;
         near_q    <= din;
         near2_q   <= near_q;
         far_q     <= dfar;
         preadd_q  <= preadd_t'(near2_q) + preadd_t'(far_q);   // exact, 17 bits
         product_q <= acc_t'(preadd_q) * acc_t'(coef_q);        // mod 2^32
         casc_out  <= product_q + casc_in;
      end
   end

   // two registers per tap keep the near data in step with the cascade
   assign dnext = near2_q;

endmodule

// File: fir/fir_sym_systolic.sv
`timescale 1ns/10ps

// filter core: delay line plus a chain of nbtap symmetric taps
// result for sample n sits on core_out after advance n + nbtap + 3
module fir_sym_systolic #(
   parameter int nbtap = 4
)
(
   input  logic             clk,
   input  logic             reset,
   input  logic             advance,
   input  fir_pkg::coef_t   coefs [nbtap],
   input  fir_pkg::sample_t din,
   output fir_pkg::acc_t    core_out
);

   import fir_pkg::*;

   localparam int FILL   = 2*nbtap;
   localparam int FILL_W = $clog2(FILL+1);

   sample_t           far_raw;
   sample_t           far_data;
   sample_t           chain [nbtap];      // dnext of each tap
   sample_t           tap_din [nbtap];
   acc_t              casc [nbtap];       // casc_out of each tap
   acc_t              casc_in [nbtap];
   logic [FILL_W-1:0] fill_cnt;           // advances since reset, saturating

   // Samples older than the first accept must read as zero. Each data path
   // is held at zero until the history behind it is real, so the registers
   // inside the taps flush to a clean cascade during the warm-up.
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         fill_cnt <= '0;
      end
      else if (advance && fill_cnt != FILL_W'(FILL))
      begin
         fill_cnt <= fill_cnt + 1'b1;
      end
   end

   assign far_data = (fill_cnt == FILL_W'(FILL)) ? far_raw : '0;   // x[k-2*nbtap]

   fir_delay_line #(
      .nbtap(nbtap)
   ) delay0 (
      .clk     (clk),
      .advance (advance),
      .din     (din),
      .dout    (far_raw)
   );

   for (genvar i = 0; i < nbtap; i++)
   begin : g_tap
      if (i == 0)
      begin : g_first
         assign tap_din[i] = din;
         assign casc_in[i] = '0;      // head of the cascade
      end
      else
      begin : g_rest
         // chain carries x[k-2i] into tap i
         assign tap_din[i] = (fill_cnt >= FILL_W'(2*i)) ? chain[i-1] : '0;
         assign casc_in[i] = casc[i-1];
      end

      fir_sym_tap tap (
         .clk      (clk),
         .advance  (advance),
         .coef     (coefs[i]),
         .din      (tap_din[i]),
         .dfar     (far_data),
         .casc_in  (casc_in[i]),
         .dnext    (chain[i]),
         .casc_out (casc[i])
      );
   end

   assign core_out = casc[nbtap-1];   // last cascade sum

endmodule

// File: hdl/coef_bank.sv
`timescale 1ns/10ps

// double buffered coefficients: the host fills the shadow set while
// the active set keeps driving the filter, then commits in one edge
module coef_bank #(
   parameter int nbtap = 4
)
(
   input  logic                clk,
   input  logic                reset,
   input  logic                cmd_valid,
   output logic                cmd_ready,
   input  fir_pkg::coef_cmd_t  cmd,
   output fir_pkg::coef_t      coefs [nbtap]
);

   import fir_pkg::*;

   coef_t shadow [nbtap];
   coef_t active [nbtap];
   logic  cmd_fire;

   assign cmd_fire = cmd_valid && cmd_ready;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         cmd_ready <= 1'b0;
         for (int i = 0; i < nbtap; i++)
         begin
            shadow[i] <= '0;
            active[i] <= '0;
         end
      end
      else
      begin
         cmd_ready <= 1'b1;   // never busy
         if (cmd_fire)
         begin
            case (cmd.op)
               COEF_WRITE:
               begin
                  // index of nbtap or more matches no slot
                  for (int i = 0; i < nbtap; i++)
                  begin
                     if (cmd.index == COEF_IDX_W'(i))
                     begin
                        shadow[i] <= cmd.value;
                     end
                  end
               end
               COEF_COMMIT:
               begin
                  for (int i = 0; i < nbtap; i++)
                  begin
                     active[i] <= shadow[i];
                  end
               end
               default:
               begin
                  // unknown opcode, dropped
               end
            endcase
         end
      end
   end

   assign coefs = active;

endmodule

// File: hdl/fir_stream_ctrl.sv
`timescale 1ns/10ps

// valid/ready control around the filter core
// the core only moves on an accepted sample, so a stalled output
// freezes the whole pipeline and nothing is dropped
module fir_stream_ctrl #(
   parameter int nbtap = 4
)
(
   input  logic          clk,
   input  logic          reset,
   input  logic          in_valid,
   output logic          in_ready,
   output logic          out_valid,
   input  logic          out_ready,
   input  fir_pkg::acc_t core_out,
   output logic          advance,
   output fir_pkg::acc_t out_data
);

   // core depth in accepted samples
   localparam int LAT   = nbtap + 4;
   localparam int CNT_W = $clog2(LAT+1);

   logic [CNT_W-1:0] warm_cnt;   // accepts seen, stops at LAT
   logic             primed;
   logic             load;

   assign primed = (warm_cnt == CNT_W'(LAT));

   // room in the output register, either empty or emptied this edge
   assign in_ready = !out_valid || out_ready;
   assign advance  = in_valid && in_ready;
   assign load     = advance && primed;   // core_out now holds a real result

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         warm_cnt <= '0;
      end
      else if (advance && !primed)
      begin
         warm_cnt <= warm_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         out_valid <= 1'b0;
      end
      else if (load)
      begin
         out_valid <= 1'b1;
      end
      else if (out_ready)
      begin
         out_valid <= 1'b0;   // taken, nothing new behind it
      end
   end

   // holding register, stable while the sink stalls
   always_ff @(posedge clk)
   begin
      if (load)
      begin
         out_data <= core_out;
      end
   end

endmodule

// File: hdl/fir_top.sv
`timescale 1ns/10ps

// streaming symmetric FIR with host loadable coefficients
module fir_top #(
   parameter int nbtap = 4
)
(
   input  logic               clk,
   input  logic               reset,
   // coefficient command port
   input  logic               cmd_valid,
   output logic               cmd_ready,
   input  fir_pkg::coef_cmd_t cmd,
   // sample stream in
   input  logic               in_valid,
   output logic               in_ready,
   input  fir_pkg::sample_t   in_data,
   // result stream out
   output logic               out_valid,
   input  logic               out_ready,
   output fir_pkg::acc_t      out_data
);

   import fir_pkg::*;

   coef_t coefs [nbtap];   // active set
   acc_t  core_out;
   logic  advance;         // high on each accepted sample

   coef_bank #(
      .nbtap(nbtap)
   ) bank0 (
      .clk       (clk),
      .reset     (reset),
      .cmd_valid (cmd_valid),
      .cmd_ready (cmd_ready),
      .cmd       (cmd),
      .coefs     (coefs)
   );

   fir_sym_systolic #(
      .nbtap(nbtap)
   ) core0 (
      .clk      (clk),
      .reset    (reset),
      .advance  (advance),
      .coefs    (coefs),
      .din      (in_data),
      .core_out (core_out)
   );

   fir_stream_ctrl #(
      .nbtap(nbtap)
   ) ctrl0 (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .core_out  (core_out),
      .advance   (advance),
      .out_data  (out_data)
   );

endmodule

// File: sim/fir_tb.sv
`timescale 1ns/10ps

module fir_tb;

   import fir_pkg::*;

   localparam int NBTAP     = 4;
   localparam int LAT       = NBTAP + 4;    // core depth in accepted samples
   localparam int PAD       = 2*LAT;        // twice the core depth of trailing zeros
   localparam int NUM_TESTS = 7;
   localparam int NUM_SETS  = 4;
   localparam int NUM_IDX   = 1 << COEF_IDX_W;

   logic      clk = 1'b0;
   logic      reset;
   logic      cmd_valid;
   logic      cmd_ready;
   coef_cmd_t cmd;
   logic      in_valid;
   logic      in_ready;
   sample_t   in_data;
   logic      out_valid;
   logic      out_ready;
   acc_t      out_data;

   // coefficient sets with set 2 refilled from the LFSR at start
   coef_t coef_tab [NUM_SETS][NBTAP] = '{
      '{16'sd7, 16'sd14, -16'sd138, 16'sd129},
      '{16'sd32767, 16'sh8000, 16'sd32767, 16'sd32767},   // large sums that wrap in 32 bits
      '{16'sd0, 16'sd0, 16'sd0, 16'sd0},
      '{-16'sd3, 16'sd1000, -16'sd25000, 16'sd12}
   };

   sample_t fixed_list [8] = '{16'sd1, -16'sd1, 16'sd32767, 16'sh8000,
                               16'sd100, -16'sd100, 16'sd0, 16'sd5};

   // one test per column index
   string test_name [NUM_TESTS] = '{"impulse", "random_data", "wrap", "stalls",
                                    "shadow_hold", "shadow_commit", "impulse_stalled"};
   int    test_set   [NUM_TESTS] = '{0, 2, 1, 2, 3, 3, 0};
   int    test_count [NUM_TESTS] = '{1, 40, 40, 60, 30, 30, 1};
   bit    test_lfsr  [NUM_TESTS] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0};
   bit    test_stall [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1};
   bit    test_commit[NUM_TESTS] = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1};

   logic [31:0] lfsr_state;
   sample_t     hist [2*NBTAP];    // model history with the newest first
   coef_t       model_coefs [NBTAP];
   acc_t        exp_q [$];
   string       cur_name;
   bit          stall_mode;

   fir_top #(
      .nbtap(NBTAP)
   ) dut0 (
      .clk       (clk),
      .reset     (reset),
      .cmd_valid (cmd_valid),
      .cmd_ready (cmd_ready),
      .cmd       (cmd),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .in_data   (in_data),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_data  (out_data)
   );

   always #4 clk = ~clk;   // 8 ns period

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   task automatic abort_run(input string what);
      $display("%s", what);
      $display("Finished with errors");
      $fatal(1);
   endtask

   task automatic check_acc(input acc_t expected, input acc_t actual, input string name);
      if (actual !== expected)
      begin
         abort_run($sformatf("Mismatch in %s: expected %0d, actual %0d",
                             name, expected, actual));
      end
   endtask

   task automatic check_coef_ready(input logic ready, input string name);
      if (ready !== 1'b1)
      begin
         abort_run($sformatf("Error: cmd_ready was low during a command in %s", name));
      end
   endtask

   // symmetric list h0..h(n-1), h(n-1)..h0 over the last 2*nbtap samples
   task automatic model_accept(input sample_t s);
      acc_t  sum;
      coef_t c;
      for (int m = 2*NBTAP-1; m > 0; m--)
      begin
         hist[m] = hist[m-1];
      end
      hist[0] = s;
      sum = '0;
      for (int m = 0; m < 2*NBTAP; m++)
      begin
         c = (m < NBTAP) ? model_coefs[m] : model_coefs[2*NBTAP-1-m];
         sum = sum + acc_t'(c) * acc_t'(hist[m]);   // wraps mod 2^32
      end
      exp_q.push_back(sum);
   endtask

   task automatic send_cmd(input coef_op_t cmd_op, input int idx, input coef_t val);
      cmd_valid <= 1'b1;
      cmd       <= '{op: cmd_op, index: COEF_IDX_W'(idx), value: val};
      @(posedge clk);
      check_coef_ready(cmd_ready, cur_name);   // transfer edge
   endtask

   task automatic load_coefs(input int set, input bit commit);
      for (int i = 0; i < NBTAP; i++)
      begin
         send_cmd(COEF_WRITE, i, coef_tab[set][i]);
      end
      for (int i = NBTAP; i < NUM_IDX; i++)
      begin
         send_cmd(COEF_WRITE, i, coef_t'(take_bits(16)));   // out of range index has no effect
      end
      if (commit)
      begin
         send_cmd(COEF_COMMIT, 0, '0);
         for (int i = 0; i < NBTAP; i++)
         begin
            model_coefs[i] = coef_tab[set][i];
         end
      end
      cmd_valid <= 1'b0;
      @(posedge clk);
      check_coef_ready(cmd_ready, cur_name);
   endtask

   task automatic send_sample(input sample_t s);
      in_valid <= 1'b1;
      in_data  <= s;
      @(posedge clk);
      while (!in_ready)
      begin
         @(posedge clk);
      end
      model_accept(s);
   endtask

   task automatic run_test(input int t);
      sample_t samples [$];
      cur_name = test_name[t];
      load_coefs(test_set[t], test_commit[t]);
      for (int k = 0; k < test_count[t]; k++)
      begin
         if (test_lfsr[t])
            samples.push_back(sample_t'(take_bits(16)));
         else
            samples.push_back(fixed_list[k % 8]);
      end
      for (int k = 0; k < PAD; k++)
      begin
         samples.push_back('0);
      end
      stall_mode = test_stall[t];
      foreach (samples[k])
      begin
         send_sample(samples[k]);
      end
      in_valid <= 1'b0;
      while (exp_q.size() != LAT)   // all due results taken
      begin
         @(posedge clk);
      end
      stall_mode = 1'b0;
      @(posedge clk);
   endtask

   initial
   begin
      reset       = 1'b1;
      cmd_valid   = 1'b0;
      cmd         = '{op: COEF_WRITE, index: '0, value: '0};
      in_valid    = 1'b0;
      in_data     = '0;
      lfsr_state  = 32'h51fe;
      stall_mode  = 1'b0;
      cur_name    = "reset";
      for (int m = 0; m < 2*NBTAP; m++)
      begin
         hist[m] = '0;
      end
      for (int i = 0; i < NBTAP; i++)
      begin
         model_coefs[i] = '0;
      end
      repeat (2) @(posedge clk);
      reset <= 1'b0;
      repeat (2) @(posedge clk);   // cmd_ready comes up one cycle after reset
      for (int i = 0; i < NBTAP; i++)
      begin
         coef_tab[2][i] = coef_t'(take_bits(16));
      end
      for (int t = 0; t < NUM_TESTS; t++)
      begin
         run_test(t);
      end
      $display("Finished with no errors");
      $finish;
   end

   // output side that owns out_ready
   initial
   begin
      acc_t expected;
      acc_t held;
      logic stalled;
      out_ready = 1'b0;
      stalled   = 1'b0;
      held      = '0;
      forever
      begin
         @(posedge clk);
         if (reset)
         begin
            out_ready <= 1'b0;
            stalled = 1'b0;
         end
         else
         begin
            if (stalled)
            begin
               if (out_valid !== 1'b1)
                  abort_run($sformatf("Error: out_valid dropped while stalled in %s", cur_name));
               else
                  check_acc(held, out_data, {cur_name, " held"});
            end
            if (out_valid && out_ready)
            begin
               if (exp_q.size() == 0)
               begin
                  abort_run($sformatf("Error: unexpected result in %s", cur_name));
               end
               else
               begin
                  expected = exp_q.pop_front();
                  check_acc(expected, out_data, cur_name);
               end
            end
            stalled = out_valid && !out_ready;
            held    = out_data;
            if (stall_mode)
               out_ready <= (take_bits(2) != 32'd0);   // ready three times in four
            else
               out_ready <= 1'b1;
         end
      end
   end

   // watchdog allows 20 cycles per sample plus command overhead
   initial
   begin
      int limit;
      limit = 0;
      for (int t = 0; t < NUM_TESTS; t++)
      begin
         limit = limit + test_count[t] + PAD + LAT;
      end
      limit = limit * 20 + NUM_TESTS * (NUM_IDX + 8) + 200;
      repeat (limit) @(posedge clk);
      abort_run($sformatf("Error: output stream stalled, run not done after %0d cycles", limit));
   end

endmodule

// File: project.f
common/fir_pkg.sv
fir/fir_delay_line.sv
fir/fir_sym_tap.sv
fir/fir_sym_systolic.sv
hdl/coef_bank.sv
hdl/fir_stream_ctrl.sv
hdl/fir_top.sv
sim/fir_tb.sv

// File: run_sim.sh
#!/bin/sh
# build fir_tb with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary -f project.f --top-module fir_tb -Mdir obj_dir -o fir_tb_sim \
   || { echo "build failed"; exit 1; }
./obj_dir/fir_tb_sim > sim.log 2>&1
cat sim.log
grep -q "Finished with no errors" sim.log && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
